// ==== rtl/mrd_pkg.sv ====
package mrd_pkg;

localparam int MRD_LANES = 5;
localparam int MRD_CW    = 14; // Fractional bits of the coefficients

typedef struct packed {
	logic signed [15:0] im;
	logic signed [15:0] re;
} mrd_sample_t;

// APB data word seen either raw or as a complex sample
typedef union packed {
	logic [31:0] raw;
	mrd_sample_t smp;
} mrd_sample_u;

typedef mrd_sample_t [MRD_LANES-1:0] mrd_group_t;

typedef struct packed {
	logic       valid;
	logic [2:0] factor;    // Radix 2 to 5
	logic [4:0] bank_addr;
	mrd_group_t data;
} mrd_xfer_t;

// round(16384 * cos(2*pi*j/r)), rows r = 2..5, columns j = 0..4
localparam logic signed [17:0] mrd_cos [2:5][0:4] = '{
	'{18'sd16384, -18'sd16384, 18'sd16384, -18'sd16384, 18'sd16384},
	'{18'sd16384, -18'sd8192, -18'sd8192, 18'sd16384, -18'sd8192},
	'{18'sd16384, 18'sd0, -18'sd16384, 18'sd0, 18'sd16384},
	'{18'sd16384, 18'sd5063, -18'sd13255, -18'sd13255, 18'sd5063}
};

// round(16384 * sin(2*pi*j/r))
localparam logic signed [17:0] mrd_sin [2:5][0:4] = '{
	'{18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0},
	'{18'sd0, 18'sd14189, -18'sd14189, 18'sd0, 18'sd14189},
	'{18'sd0, 18'sd16384, 18'sd0, -18'sd16384, 18'sd0},
	'{18'sd0, 18'sd15582, 18'sd9630, -18'sd9630, -18'sd15582}
};

// APB map
localparam logic [11:0] MRD_REG_CTRL   = 12'h000;
localparam logic [11:0] MRD_REG_STATUS = 12'h004;
localparam logic [11:0] MRD_BANK0_BASE = 12'h400;
localparam logic [11:0] MRD_BANK1_BASE = 12'h800;

endpackage

// ==== rtl/mrd_group_bank.sv ====
`timescale 1ns/1ps

module mrd_group_bank #(
	parameter int GROUPS = 32
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               apb_sel,
	input  logic               apb_write,
	input  logic [7:0]         apb_addr,  // Group in 7:3, lane in 2:0
	input  logic [31:0]        apb_wdata,
	output logic [31:0]        apb_rdata,
	input  logic               rd_en,
	input  logic [4:0]         rd_addr,
	input  logic [2:0]         factor,
	output mrd_pkg::mrd_xfer_t rd_xfer,
	input  mrd_pkg::mrd_xfer_t wr_xfer
);

mrd_pkg::mrd_group_t  mem [GROUPS];
mrd_pkg::mrd_sample_u wr_word;
mrd_pkg::mrd_sample_u rd_word;
logic [4:0]           apb_grp;
logic [2:0]           apb_lane;
logic                 rd_valid;
logic [2:0]           rd_factor;
logic [4:0]           rd_addr_q;
mrd_pkg::mrd_group_t  rd_data;

assign apb_grp  = apb_addr[7:3];
assign apb_lane = apb_addr[2:0];

assign wr_word.raw = apb_wdata;
assign rd_word.smp = mem[apb_grp][apb_lane];
assign apb_rdata   = rd_word.raw;

always_ff @(posedge clk) begin
	// Pass writes and APB writes never overlap, busy blocks the latter
	if (wr_xfer.valid) begin
		mem[wr_xfer.bank_addr] <= wr_xfer.data;
	end else if (apb_sel && apb_write) begin
		mem[apb_grp][apb_lane] <= wr_word.smp;
	end
	rd_factor <= factor;
	rd_addr_q <= rd_addr;
	rd_data   <= mem[rd_addr];
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		rd_valid <= 1'b0;
	end else begin
		rd_valid <= rd_en;
	end
end

assign rd_xfer = '{valid: rd_valid, factor: rd_factor, bank_addr: rd_addr_q, data: rd_data};

endmodule

// ==== rtl/mrd_switch_rdx2345.sv ====
`timescale 1ns/1ps

module mrd_switch_rdx2345 (
	input  logic               sw,
	input  mrd_pkg::mrd_xfer_t from_mem0,
	input  mrd_pkg::mrd_xfer_t from_mem1,
	input  mrd_pkg::mrd_xfer_t from_rdx2345,
	output mrd_pkg::mrd_xfer_t to_mem0,
	output mrd_pkg::mrd_xfer_t to_mem1,
	output mrd_pkg::mrd_xfer_t to_rdx2345
);

// Source bank feeds the engine
assign to_rdx2345 = (sw) ? from_mem1 : from_mem0;

// Result goes to the other bank, the idle side sees all zero
assign to_mem0 = (sw) ? from_rdx2345 : '0;
assign to_mem1 = (sw) ? '0 : from_rdx2345;

endmodule

// ==== rtl/mrd_rdx2345.sv ====
`timescale 1ns/1ps

module mrd_rdx2345 (
	input  logic               clk,
	input  logic               arst_n,
	input  mrd_pkg::mrd_xfer_t in_xfer,
	output mrd_pkg::mrd_xfer_t out_xfer
);

logic signed [33:0]  m_re [5][5]; // [k][n]
logic signed [33:0]  m_im [5][5];
logic signed [33:0]  p_re [5][5];
logic signed [33:0]  p_im [5][5];
logic                s1_valid;
logic [2:0]          s1_factor;
logic [4:0]          s1_addr;
mrd_pkg::mrd_group_t sum_grp;
logic                s2_valid;
logic [2:0]          s2_factor;
logic [4:0]          s2_addr;
mrd_pkg::mrd_group_t s2_data;

// x[n] * W^(n*k mod r), W = cos - j*sin
always_comb begin
	int                 r;
	int                 j;
	logic signed [17:0] c;
	logic signed [17:0] s;
	logic signed [15:0] xr;
	logic signed [15:0] xi;
	r = (in_xfer.factor >= 3'd2 && in_xfer.factor <= 3'd5) ? int'(in_xfer.factor) : 2;
	for (int k = 0; k < 5; k++) begin
		for (int n = 0; n < 5; n++) begin
			j  = (n * k) % r;
			c  = mrd_pkg::mrd_cos[r][j];
			s  = mrd_pkg::mrd_sin[r][j];
			xr = in_xfer.data[n].re;
			xi = in_xfer.data[n].im;
			m_re[k][n] = xr * c + xi * s;
			m_im[k][n] = xi * c - xr * s;
		end
	end
end

// Sum over n < r, then shift and truncate to 16 bits
always_comb begin
	int                 r;
	logic signed [36:0] acc_re;
	logic signed [36:0] acc_im;
	logic signed [36:0] sh_re;
	logic signed [36:0] sh_im;
	r       = int'(s1_factor);
	sum_grp = '0;
	for (int k = 0; k < 5; k++) begin
		acc_re = '0;
		acc_im = '0;
		for (int n = 0; n < 5; n++) begin
			if (n < r) begin
				acc_re = acc_re + p_re[k][n];
				acc_im = acc_im + p_im[k][n];
			end
		end
		sh_re = acc_re >>> mrd_pkg::MRD_CW;
		sh_im = acc_im >>> mrd_pkg::MRD_CW;
		if (k < r) begin
			sum_grp[k].re = sh_re[15:0];
			sum_grp[k].im = sh_im[15:0];
		end
	end
end

always_ff @(posedge clk) begin
	p_re      <= m_re;
	p_im      <= m_im;
	s1_factor <= in_xfer.factor;
	s1_addr   <= in_xfer.bank_addr;
	s2_data   <= sum_grp;
	s2_factor <= s1_factor;
	s2_addr   <= s1_addr;
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		s1_valid <= 1'b0;
		s2_valid <= 1'b0;
	end else begin
		s1_valid <= in_xfer.valid;
		s2_valid <= s1_valid;
	end
end

assign out_xfer = '{valid: s2_valid, factor: s2_factor, bank_addr: s2_addr, data: s2_data};

endmodule

// ==== rtl/mrd_pass_ctrl.sv ====
`timescale 1ns/1ps

module mrd_pass_ctrl #(
	parameter int GROUPS = 32
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic        reg_sel,
	input  logic        bank_sel,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] reg_rdata,
	output logic        pslverr,
	output logic        bank_wr_ok,
	output logic        rd_en,
	output logic [4:0]  rd_addr,
	output logic [2:0]  factor,
	output logic        sw
);

logic       busy;
logic [2:0] radix;
logic [5:0] count;
logic [4:0] wr_cnt;
logic [2:0] vld_sr;    // rd_en seen at bank out, stage 1, stage 2
logic       acc;
logic       ctrl_hit;
logic       ctrl_wr;
logic [2:0] new_radix;
logic [5:0] new_count;
logic       fields_ok;
logic       start_ok;
logic       start_bad;

assign acc       = psel & penable;
assign ctrl_hit  = acc & reg_sel & pwrite & (paddr == mrd_pkg::MRD_REG_CTRL);
assign ctrl_wr   = ctrl_hit & ~busy; // CTRL is frozen during a pass
assign new_radix = pwdata[6:4];
assign new_count = pwdata[13:8];

assign fields_ok = (new_radix >= 3'd2) && (new_radix <= 3'd5) &&
                   (new_count != 6'd0) && (int'(new_count) <= GROUPS);
assign start_ok  = ctrl_wr & pwdata[0] & fields_ok;
assign start_bad = ctrl_hit & pwdata[0] & ~fields_ok;

assign pslverr    = start_bad | (acc & bank_sel & busy);
assign bank_wr_ok = ~busy;
assign factor     = radix;

always_comb begin
	reg_rdata = '0;
	if (paddr == mrd_pkg::MRD_REG_STATUS) begin
		reg_rdata[1:0] = {sw, busy};
	end else begin
		reg_rdata[6:4]  = radix;
		reg_rdata[13:8] = count;
	end
end

// Plain writes store the fields, a start only with legal fields
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		radix <= '0;
		count <= '0;
	end else if (ctrl_wr && (!pwdata[0] || fields_ok)) begin
		radix <= new_radix;
		count <= new_count;
	end
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		busy    <= 1'b0;
		sw      <= 1'b0;
		rd_en   <= 1'b0;
		rd_addr <= '0;
		wr_cnt  <= '0;
		vld_sr  <= '0;
	end else begin
		vld_sr <= {vld_sr[1:0], rd_en};
		if (start_ok) begin
			busy    <= 1'b1;
			rd_en   <= 1'b1;
			rd_addr <= '0;
			wr_cnt  <= '0;
		end else if (rd_en) begin
			if ({1'b0, rd_addr} == count - 6'd1) begin
				rd_en <= 1'b0;
			end else begin
				rd_addr <= rd_addr + 5'd1;
			end
		end
		if (vld_sr[2]) begin // Engine result written this cycle
			if ({1'b0, wr_cnt} == count - 6'd1) begin
				busy   <= 1'b0;
				sw     <= ~sw;
				wr_cnt <= '0;
			end else begin
				wr_cnt <= wr_cnt + 5'd1;
			end
		end
	end
end

endmodule

// ==== rtl/mrd_fft_top.sv ====
`timescale 1ns/1ps

module mrd_fft_top #(
	parameter int GROUPS = 32
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

logic               acc;
logic               reg_sel;
logic               win0;
logic               win1;
logic               bank_win;
logic [4:0]         grp;
logic [2:0]         lane;
logic               addr_ok;
logic               dec_err;
logic               ctrl_err;
logic               bank_wr_ok;
logic               b0_sel;
logic               b1_sel;
logic [31:0]        reg_rdata;
logic [31:0]        b0_rdata;
logic [31:0]        b1_rdata;
logic               rd_en;
logic [4:0]         rd_addr;
logic [2:0]         factor;
logic               sw;
mrd_pkg::mrd_xfer_t b0_rd;
mrd_pkg::mrd_xfer_t b1_rd;
mrd_pkg::mrd_xfer_t b0_wr;
mrd_pkg::mrd_xfer_t b1_wr;
mrd_pkg::mrd_xfer_t rdx_in;
mrd_pkg::mrd_xfer_t rdx_out;

assign acc      = psel & penable;
assign reg_sel  = (paddr == mrd_pkg::MRD_REG_CTRL) || (paddr == mrd_pkg::MRD_REG_STATUS);
assign win0     = paddr[11:10] == mrd_pkg::MRD_BANK0_BASE[11:10];
assign win1     = paddr[11:10] == mrd_pkg::MRD_BANK1_BASE[11:10];
assign bank_win = win0 | win1;
assign grp      = paddr[9:5];
assign lane     = paddr[4:2];
assign addr_ok  = (int'(lane) < mrd_pkg::MRD_LANES) && (int'(grp) < GROUPS);
assign dec_err  = acc & ~reg_sel & ~(bank_win & addr_ok); // Unmapped, bad lane or group

// Bank writes are held off while a pass runs
assign b0_sel = acc & win0 & addr_ok & (~pwrite | bank_wr_ok);
assign b1_sel = acc & win1 & addr_ok & (~pwrite | bank_wr_ok);

assign prdata  = reg_sel ? reg_rdata : win0 ? b0_rdata : win1 ? b1_rdata : '0;
assign pready  = 1'b1;
assign pslverr = dec_err | ctrl_err;

mrd_pass_ctrl #(.GROUPS(GROUPS)) u_ctrl (
	.clk(clk), .arst_n(arst_n),
	.psel(psel), .penable(penable), .pwrite(pwrite),
	.reg_sel(reg_sel), .bank_sel(bank_win), .paddr(paddr), .pwdata(pwdata),
	.reg_rdata(reg_rdata), .pslverr(ctrl_err), .bank_wr_ok(bank_wr_ok),
	.rd_en(rd_en), .rd_addr(rd_addr), .factor(factor), .sw(sw)
);

mrd_group_bank #(.GROUPS(GROUPS)) bank0 (
	.clk(clk), .arst_n(arst_n),
	.apb_sel(b0_sel), .apb_write(pwrite), .apb_addr(paddr[9:2]), .apb_wdata(pwdata),
	.apb_rdata(b0_rdata),
	.rd_en(rd_en), .rd_addr(rd_addr), .factor(factor),
	.rd_xfer(b0_rd), .wr_xfer(b0_wr)
);

mrd_group_bank #(.GROUPS(GROUPS)) bank1 (
	.clk(clk), .arst_n(arst_n),
	.apb_sel(b1_sel), .apb_write(pwrite), .apb_addr(paddr[9:2]), .apb_wdata(pwdata),
	.apb_rdata(b1_rdata),
	.rd_en(rd_en), .rd_addr(rd_addr), .factor(factor),
	.rd_xfer(b1_rd), .wr_xfer(b1_wr)
);

mrd_switch_rdx2345 u_switch (
	.sw(sw),
	.from_mem0(b0_rd), .from_mem1(b1_rd), .from_rdx2345(rdx_out),
	.to_mem0(b0_wr), .to_mem1(b1_wr), .to_rdx2345(rdx_in)
);

mrd_rdx2345 u_rdx (
	.clk(clk), .arst_n(arst_n),
	.in_xfer(rdx_in), .out_xfer(rdx_out)
);

endmodule

// ==== verification/mrd_fft_tb.sv ====
`timescale 1ns/1ps

module mrd_fft_tb;

localparam int GROUPS = 32;
localparam int LIMIT  = 20000; // About 3700 cycles of APB traffic plus margin

logic        clk;
logic        arst_n;
logic        psel;
logic        penable;
logic        pwrite;
logic [11:0] paddr;
logic [31:0] pwdata;
logic [31:0] prdata;
logic        pready;
logic        pslverr;

logic [31:0] mdl [2][GROUPS][5]; // Expected bank contents
logic [31:0] seed;
int          errors;
int          cycles;

mrd_fft_top #(.GROUPS(GROUPS)) dut0 (
	.clk(clk), .arst_n(arst_n),
	.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
	.prdata(prdata), .pready(pready), .pslverr(pslverr)
);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

always @(posedge clk) begin
	cycles = cycles + 1;
	if (cycles >= LIMIT) begin
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("Verification failed");
		$finish;
	end
end

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [11:0] lane_addr(input int bank, input int grp, input int lane);
	logic [11:0] base;
	base = (bank == 0) ? mrd_pkg::MRD_BANK0_BASE : mrd_pkg::MRD_BANK1_BASE;
	return base | 12'(grp << 5) | 12'(lane << 2);
endfunction

function automatic logic [31:0] ctrl_word(input int r, input int count, input int start);
	return 32'((count << 8) | (r << 4) | start);
endfunction

task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
	assert (got === exp) else begin
		errors++;
		$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

// All APB tasks start and end 1 ns after a rising edge
task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
	psel    = 1'b1;
	pwrite  = 1'b1;
	penable = 1'b0;
	paddr   = addr;
	pwdata  = data;
	@(posedge clk);
	#1 penable = 1'b1;
	#4 err = pslverr; // Mid access phase
	@(posedge clk);
	#1 psel = 1'b0;
	penable = 1'b0;
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
	psel    = 1'b1;
	pwrite  = 1'b0;
	penable = 1'b0;
	paddr   = addr;
	@(posedge clk);
	#1 penable = 1'b1;
	#4 data = prdata;
	err = pslverr;
	@(posedge clk);
	#1 psel = 1'b0;
	penable = 1'b0;
endtask

task automatic do_reset();
	arst_n = 1'b0;
	repeat (4) @(posedge clk);
	#1 arst_n = 1'b1;
endtask

task automatic load_bank(input int bank, input int count, input bit full);
	logic        err;
	logic [31:0] word;
	int          neg;
	for (int g = 0; g < count; g++) begin
		for (int l = 0; l < 5; l++) begin
			seed = xorshift32(seed);
			word = seed;
			if (full && g < 4) begin // Full-scale groups exercise the wrap
				neg  = (g == 0) ? 0 : (g == 1) ? 1 : (g + l) % 2;
				word = (neg != 0) ? 32'h8000_8000 : 32'h7fff_7fff;
			end
			mdl[bank][g][l] = word;
			apb_write(lane_addr(bank, g, l), word, err);
			expect_equal(32'(err), 32'd0, "pslverr on bank load");
		end
	end
endtask

task automatic check_bank(input int bank, input int count);
	logic        err;
	logic [31:0] got;
	for (int g = 0; g < count; g++) begin
		for (int l = 0; l < 5; l++) begin
			apb_read(lane_addr(bank, g, l), got, err);
			expect_equal(got, mdl[bank][g][l],
				$sformatf("bank %0d group %0d lane %0d", bank, g, l));
			expect_equal(32'(err), 32'd0, "pslverr on bank read");
		end
	end
endtask

// r-point DFT of lanes 0..r-1 with W = cos - j*sin and each sum shifted by MRD_CW and wrapped
task automatic dft_model(input int src, input int dst, input int r, input int count);
	longint      acc_re;
	longint      acc_im;
	longint      c;
	longint      s;
	longint      xr;
	longint      xi;
	logic [15:0] yr;
	logic [15:0] yi;
	for (int g = 0; g < count; g++) begin
		for (int k = 0; k < 5; k++) begin
			acc_re = 0;
			acc_im = 0;
			for (int n = 0; n < r; n++) begin
				c  = longint'(mrd_pkg::mrd_cos[r][(n * k) % r]);
				s  = longint'(mrd_pkg::mrd_sin[r][(n * k) % r]);
				xr = longint'($signed(mdl[src][g][n][15:0]));
				xi = longint'($signed(mdl[src][g][n][31:16]));
				acc_re += xr * c + xi * s;
				acc_im += xi * c - xr * s;
			end
			yr = 16'(acc_re >>> mrd_pkg::MRD_CW);
			yi = 16'(acc_im >>> mrd_pkg::MRD_CW);
			mdl[dst][g][k] = (k < r) ? {yi, yr} : 32'd0;
		end
	end
endtask

task automatic wait_idle();
	logic        err;
	logic [31:0] st;
	st = 32'd1;
	while (st[0]) begin
		apb_read(mrd_pkg::MRD_REG_STATUS, st, err);
		expect_equal(32'(err), 32'd0, "pslverr on STATUS poll");
	end
endtask

task automatic run_pass(input int r, input int count);
	logic err;
	apb_write(mrd_pkg::MRD_REG_CTRL, ctrl_word(r, count, 1), err);
	expect_equal(32'(err), 32'd0, "pslverr on start");
	wait_idle();
endtask

task automatic test_registers();
	logic        err;
	logic [31:0] rd;
	do_reset();
	apb_read(mrd_pkg::MRD_REG_STATUS, rd, err);
	expect_equal(rd, 32'd0, "STATUS after reset");
	expect_equal(32'(err), 32'd0, "pslverr on STATUS read");
	expect_equal(32'(pready), 32'd1, "pready");
	apb_write(mrd_pkg::MRD_REG_CTRL, ctrl_word(3, 5, 0), err);
	expect_equal(32'(err), 32'd0, "pslverr on CTRL write");
	apb_read(mrd_pkg::MRD_REG_CTRL, rd, err);
	expect_equal(rd, ctrl_word(3, 5, 0), "CTRL readback");
	expect_equal(32'(err), 32'd0, "pslverr on CTRL read");
endtask

task automatic test_single_pass(input int r, input int count, input bit full);
	do_reset();
	load_bank(0, count, full);
	run_pass(r, count);
	dft_model(0, 1, r, count);
	check_bank(0, count);
	check_bank(1, count);
endtask

task automatic test_ping_pong();
	logic        err;
	logic [31:0] rd;
	test_single_pass(3, 16, 1'b0);
	apb_read(mrd_pkg::MRD_REG_STATUS, rd, err);
	expect_equal(rd, 32'h2, "STATUS after first pass");
	expect_equal(32'(err), 32'd0, "pslverr on STATUS read");
	run_pass(5, 16); // Bank 1 back into bank 0
	dft_model(1, 0, 5, 16);
	check_bank(0, 16);
	check_bank(1, 16);
	apb_read(mrd_pkg::MRD_REG_STATUS, rd, err);
	expect_equal(rd, 32'h0, "STATUS after second pass");
	expect_equal(32'(err), 32'd0, "pslverr on STATUS read");
endtask

task automatic test_errors();
	logic        err;
	logic [31:0] rd;
	do_reset();
	load_bank(0, 8, 1'b0);
	apb_write(mrd_pkg::MRD_REG_CTRL, ctrl_word(6, 8, 1), err);
	expect_equal(32'(err), 32'd1, "pslverr on radix 6 start");
	apb_write(mrd_pkg::MRD_REG_CTRL, ctrl_word(2, 0, 1), err);
	expect_equal(32'(err), 32'd1, "pslverr on count 0 start");
	apb_read(mrd_pkg::MRD_REG_STATUS, rd, err);
	expect_equal(rd, 32'd0, "STATUS after refused starts");
	apb_read(mrd_pkg::MRD_REG_CTRL, rd, err);
	expect_equal(rd, 32'd0, "CTRL after refused starts");
	apb_write(lane_addr(0, 2, 5), 32'hdead_beef, err);
	expect_equal(32'(err), 32'd1, "pslverr on lane 5 write");
	apb_read(lane_addr(0, 2, 5), rd, err);
	expect_equal(32'(err), 32'd1, "pslverr on lane 5 read");
	// Write into the source bank while the pass runs
	apb_write(mrd_pkg::MRD_REG_CTRL, ctrl_word(2, 8, 1), err);
	expect_equal(32'(err), 32'd0, "pslverr on start");
	apb_write(lane_addr(0, 0, 0), ~mdl[0][0][0], err);
	expect_equal(32'(err), 32'd1, "pslverr on bank write while busy");
	wait_idle();
	dft_model(0, 1, 2, 8);
	check_bank(0, 8);
	check_bank(1, 8);
endtask

initial begin
	arst_n  = 1'b0;
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
	paddr   = '0;
	pwdata  = '0;
	seed    = 32'hf026_2660;
	errors  = 0;
	cycles  = 0;
	test_registers();
	test_single_pass(2, 8, 1'b0);
	test_single_pass(4, 8, 1'b0);
	test_single_pass(3, 32, 1'b1);
	test_single_pass(5, 32, 1'b1);
	test_ping_pong();
	test_errors();
	$display("Checks done after %0d cycles with %0d errors", cycles, errors);
	if (errors == 0) begin
		$display("Verification passed");
	end else begin
		$display("Verification failed");
	end
	$finish;
end

endmodule

// ==== mrd_fft_top.f ====
rtl/mrd_pkg.sv
rtl/mrd_group_bank.sv
rtl/mrd_switch_rdx2345.sv
rtl/mrd_rdx2345.sv
rtl/mrd_pass_ctrl.sv
rtl/mrd_fft_top.sv
verification/mrd_fft_tb.sv

// ==== Makefile ====
obj_dir/Vmrd_fft_tb: mrd_fft_top.f $(shell cat mrd_fft_top.f)
	verilator --binary --assert -Wno-fatal -f mrd_fft_top.f --top-module mrd_fft_tb

.PHONY: run clean

run: obj_dir/Vmrd_fft_tb
	@out="$$(./obj_dir/Vmrd_fft_tb)"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
